// File: build.f
+incdir+hdl
+incdir+verification
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/stage_if.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/control_fsm.sv
hdl/datapath.sv
hdl/perf_counters.sv
hdl/mips_multicycle_top.sv
verification/tb_mips_multicycle.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mips_multicycle
DUT_TOP   ?= mips_multicycle_top
FLIST     ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx '>>> PASS' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// primary opcodes
localparam logic [5:0] opc_special = 6'h00;
localparam logic [5:0] opc_j       = 6'h02;
localparam logic [5:0] opc_beq     = 6'h04;
localparam logic [5:0] opc_bne     = 6'h05;
localparam logic [5:0] opc_addiu   = 6'h09;
localparam logic [5:0] opc_lui     = 6'h0f;
localparam logic [5:0] opc_lw      = 6'h23;
localparam logic [5:0] opc_sw      = 6'h2b;

// SPECIAL function codes
localparam logic [5:0] fn_addu = 6'h21;
localparam logic [5:0] fn_subu = 6'h23;
localparam logic [5:0] fn_and  = 6'h24;
localparam logic [5:0] fn_or   = 6'h25;
localparam logic [5:0] fn_xor  = 6'h26;
localparam logic [5:0] fn_slt  = 6'h2a;

task automatic check(input string what, input logic [31:0] expected, input logic [31:0] actual);
	if (actual !== expected) begin
		errors++;
		$display("FAILED at %0t: %s expected %h got %h", $time, what, expected, actual);
	end
endtask

function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
	return {opc_special, rs, rt, rd, 5'd0, fn};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

task automatic emit(input logic [31:0] word);
	imem[prog_len] = word;
	prog_len++;
endtask

// empty program, data memory refilled with an address-dependent pattern
task automatic clear_program();
	int i;
	for (i = 0; i < 256; i++) begin
		imem[i] = '0;
		dmem[i] = 32'h5a00_0000 ^ (i * 32'h0001_0003);
	end
	prog_len = 0;
endtask

// every result is stored at 0x40 upward
task automatic build_alu_prog();
	int k;
	emit(enc_i(opc_addiu, 1, 0, 16'h1234));
	emit(enc_i(opc_addiu, 2, 0, 16'hfffb));
	emit(enc_i(opc_lui, 3, 0, 16'habcd));
	emit(enc_r(fn_addu, 4, 1, 3));
	emit(enc_r(fn_subu, 5, 1, 2));
	emit(enc_r(fn_and, 6, 4, 2));
	emit(enc_r(fn_or, 7, 1, 3));
	emit(enc_r(fn_xor, 8, 4, 2));
	// signed compare both ways, -5 < 0x1234
	emit(enc_r(fn_slt, 9, 2, 1));
	emit(enc_r(fn_slt, 10, 1, 2));
	for (k = 1; k <= 10; k++) begin
		emit(enc_i(opc_sw, k[4:0], 0, 16'(32'h3c + 4 * k)));
	end
endtask

// loaded words used right away
task automatic build_load_prog();
	emit(enc_i(opc_lw, 11, 0, 16'h0020));
	emit(enc_i(opc_lw, 12, 0, 16'h0024));
	emit(enc_r(fn_addu, 13, 11, 12));
	emit(enc_i(opc_sw, 13, 0, 16'h0080));
	emit(enc_i(opc_sw, 11, 0, 16'h0084));
	// all-zero nop, leaves after ID
	emit(32'h0000_0000);
endtask

// must start at address 0, the jump target is absolute
task automatic build_branch_prog();
	emit(enc_i(opc_addiu, 1, 0, 16'd7));
	emit(enc_i(opc_addiu, 2, 0, 16'd7));
	// 0x08 beq taken to 0x10
	emit(enc_i(opc_beq, 2, 1, 16'd1));
	emit(enc_i(opc_addiu, 3, 0, 16'd1));
	// 0x10 bne not taken
	emit(enc_i(opc_bne, 2, 1, 16'd1));
	emit(enc_i(opc_addiu, 4, 0, 16'd2));
	// 0x18 bne taken to 0x24
	emit(enc_i(opc_bne, 0, 1, 16'd2));
	emit(enc_i(opc_addiu, 5, 0, 16'd3));
	emit(enc_i(opc_addiu, 5, 0, 16'd4));
	// 0x24 beq not taken
	emit(enc_i(opc_beq, 0, 1, 16'd5));
	// 0x28 jump to 0x34
	emit({opc_j, 26'd13});
	emit(enc_i(opc_addiu, 6, 0, 16'd5));
	emit(enc_i(opc_addiu, 6, 0, 16'd6));
	emit(enc_i(opc_sw, 4, 0, 16'h0060));
endtask

// instruction-level model of the program, with the cycle cost per class
task automatic model_run();
	logic [31:0] mregs [32];
	logic [31:0] mmem [256];
	logic [31:0] mpc;
	logic [31:0] ins;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] se;
	logic [31:0] ea;
	logic [31:0] nxt;
	logic [31:0] res;
	logic [4:0]  dst;
	logic        wr;
	int          i;
	int          steps;
	exp_fetch_q.delete();
	exp_store_addr_q.delete();
	exp_store_data_q.delete();
	exp_taken = 0;
	exp_cycles = 0;
	for (i = 0; i < 32; i++) begin
		mregs[i] = '0;
	end
	for (i = 0; i < 256; i++) begin
		mmem[i] = dmem[i];
	end
	mpc = '0;
	steps = 0;
	while (mpc != halt_pc && steps < 1000) begin
		ins = imem[mpc[9:2]];
		a = mregs[ins[25:21]];
		b = mregs[ins[20:16]];
		se = {{16{ins[15]}}, ins[15:0]};
		ea = a + se;
		nxt = mpc + 32'd4;
		res = '0;
		dst = ins[20:16];
		wr = 1'b0;
		exp_fetch_q.push_back(mpc);
		if (ins == '0) begin
			// nop leaves after ID
			exp_cycles += 3;
		end else begin
			case (ins[31:26])
				opc_special: begin
					dst = ins[15:11];
					wr = 1'b1;
					exp_cycles += 5;
					case (ins[5:0])
						fn_addu: res = a + b;
						fn_subu: res = a - b;
						fn_and:  res = a & b;
						fn_or:   res = a | b;
						fn_xor:  res = a ^ b;
						fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: begin
							wr = 1'b0;
							exp_cycles -= 1;
						end
					endcase
				end
				opc_addiu: begin
					res = ea;
					wr = 1'b1;
					exp_cycles += 5;
				end
				opc_lui: begin
					res = {ins[15:0], 16'h0000};
					wr = 1'b1;
					exp_cycles += 5;
				end
				opc_lw: begin
					res = mmem[ea[9:2]];
					wr = 1'b1;
					exp_cycles += 7;
				end
				opc_sw: begin
					exp_store_addr_q.push_back({ea[31:2], 2'b00});
					exp_store_data_q.push_back(b);
					mmem[ea[9:2]] = b;
					exp_cycles += 5;
				end
				opc_beq, opc_bne: begin
					exp_cycles += 4;
					if ((a == b) == (ins[31:26] == opc_beq)) begin
						exp_taken++;
						nxt = nxt + {se[29:0], 2'b00};
					end
				end
				opc_j: begin
					exp_cycles += 4;
					nxt = {nxt[31:28], ins[25:0], 2'b00};
				end
				default: exp_cycles += 4;
			endcase
		end
		if (wr && dst != 5'd0) begin
			mregs[dst] = res;
		end
		mpc = nxt;
		steps++;
	end
endtask

task automatic apply_reset();
	rst = 1'b1;
	inst_req_ready = 1'b0;
	inst_valid = 1'b0;
	mem_req_ready = 1'b0;
	read_data_valid = 1'b0;
	repeat (3) @(negedge clk);
	fetch_q.delete();
	store_addr_q.delete();
	store_data_q.delete();
	req_waits = 0;
	mem_waits = 0;
	rst = 1'b0;
endtask

// the core is done once it requests the halt address
task automatic wait_halt();
	int cnt;
	cnt = 0;
	@(negedge clk);
	while (!(inst_req_valid && pc == halt_pc) && cnt < 4000) begin
		@(negedge clk);
		cnt++;
	end
	if (!(inst_req_valid && pc == halt_pc)) begin
		$display("timeout: the core never requested the halt address %h", halt_pc);
		timeouts++;
	end
endtask

task automatic run_and_compare(input string name);
	int i;
	halt_pc = 32'(prog_len * 4);
	model_run();
	apply_reset();
	wait_halt();
	check({name, " fetch count"}, exp_fetch_q.size(), fetch_q.size());
	for (i = 0; i < exp_fetch_q.size() && i < fetch_q.size(); i++) begin
		check($sformatf("%s fetch %0d pc", name, i), exp_fetch_q[i], fetch_q[i]);
	end
	check({name, " store count"}, exp_store_addr_q.size(), store_addr_q.size());
	for (i = 0; i < exp_store_addr_q.size() && i < store_addr_q.size(); i++) begin
		check($sformatf("%s store %0d address", name, i), exp_store_addr_q[i],
			store_addr_q[i]);
		check($sformatf("%s store %0d data", name, i), exp_store_data_q[i],
			store_data_q[i]);
	end
	check({name, " branch_taken_count"}, exp_taken, branch_taken_count);
	// every IF cycle counts, stalled ones too
	check({name, " inst_count"}, fetch_q.size() + req_waits, inst_count);
	check({name, " mem_wait_count"}, mem_waits, mem_wait_count);
	// one RST cycle plus the per-class cost
	if (!random_waits) begin
		check({name, " cycle_count"}, exp_cycles + 1, cycle_count);
	end
endtask

task automatic test_reset();
	int i;
	halt_pc = '0;
	rst = 1'b1;
	for (i = 0; i < 3; i++) begin
		@(negedge clk);
		check("reset cycle_count", 0, cycle_count);
		check("reset inst_count", 0, inst_count);
		check("reset mem_wait_count", 0, mem_wait_count);
		check("reset branch_taken_count", 0, branch_taken_count);
		check("reset mem_read", 0, mem_read);
		check("reset mem_write", 0, mem_write);
		check("reset inst_ready", 1, inst_ready);
		check("reset read_data_ready", 1, read_data_ready);
	end
	rst = 1'b0;
	// first cycle after RST is IF
	@(negedge clk);
	check("first fetch pc", 0, pc);
	check("first fetch inst_req_valid", 1, inst_req_valid);
	check("first fetch mem_read", 0, mem_read);
	check("first fetch mem_write", 0, mem_write);
endtask

task automatic test_alu();
	clear_program();
	build_alu_prog();
	run_and_compare("alu");
endtask

task automatic test_load_use();
	clear_program();
	build_load_prog();
	run_and_compare("load use");
endtask

task automatic test_control_flow();
	clear_program();
	build_branch_prog();
	run_and_compare("control flow");
endtask

task automatic test_backpressure();
	logic [31:0] gold_addr [$];
	logic [31:0] gold_data [$];
	int          i;
	random_waits = 1'b0;
	clear_program();
	build_alu_prog();
	build_load_prog();
	run_and_compare("zero-wait mix");
	gold_addr = store_addr_q;
	gold_data = store_data_q;
	random_waits = 1'b1;
	clear_program();
	build_alu_prog();
	build_load_prog();
	run_and_compare("random-wait mix");
	check("random-wait store count", gold_addr.size(), store_addr_q.size());
	for (i = 0; i < gold_addr.size() && i < store_addr_q.size(); i++) begin
		check($sformatf("random-wait store %0d address", i), gold_addr[i], store_addr_q[i]);
		check($sformatf("random-wait store %0d data", i), gold_data[i], store_data_q[i]);
	end
	check("stalls were inserted", 1, (req_waits + mem_waits) > 0);
	random_waits = 1'b0;
endtask

// branch block first so its jump target stays put
task automatic test_cycle_timing();
	random_waits = 1'b0;
	clear_program();
	build_branch_prog();
	build_load_prog();
	build_alu_prog();
	run_and_compare("cycle timing");
endtask

`endif

// File: verification/tb_mips_multicycle.sv
`timescale 1ns/1ps

module tb_mips_multicycle;

	logic        clk;
	logic        rst;
	logic [31:0] pc;
	logic        inst_req_valid;
	logic        inst_req_ready;
	logic [31:0] instruction;
	logic        inst_valid;
	logic        inst_ready;
	logic [31:0] address;
	logic        mem_write;
	logic [31:0] write_data;
	logic        mem_read;
	logic        mem_req_ready;
	logic [31:0] read_data;
	logic        read_data_valid;
	logic        read_data_ready;
	logic [31:0] cycle_count;
	logic [31:0] inst_count;
	logic [31:0] mem_wait_count;
	logic [31:0] branch_taken_count;

	// program and data memories, word index from address bits 9:2
	logic [31:0] imem [256];
	logic [31:0] dmem [256];

	// traffic seen by the responders
	logic [31:0] fetch_q [$];
	logic [31:0] store_addr_q [$];
	logic [31:0] store_data_q [$];
	int          req_waits;
	int          mem_waits;

	// what the reference model expects
	logic [31:0] exp_fetch_q [$];
	logic [31:0] exp_store_addr_q [$];
	logic [31:0] exp_store_data_q [$];
	int          exp_taken;
	int          exp_cycles;

	int          errors;
	int          timeouts;
	int          seed;
	bit          random_waits;
	logic [31:0] halt_pc;
	int          prog_len;

	mips_multicycle_top dut_i (
		.clk(clk),
		.rst(rst),
		.pc(pc),
		.inst_req_valid(inst_req_valid),
		.inst_req_ready(inst_req_ready),
		.instruction(instruction),
		.inst_valid(inst_valid),
		.inst_ready(inst_ready),
		.address(address),
		.mem_write(mem_write),
		.write_data(write_data),
		.mem_read(mem_read),
		.mem_req_ready(mem_req_ready),
		.read_data(read_data),
		.read_data_valid(read_data_valid),
		.read_data_ready(read_data_ready),
		.cycle_count(cycle_count),
		.inst_count(inst_count),
		.mem_wait_count(mem_wait_count),
		.branch_taken_count(branch_taken_count)
	);

	// 4 ns period
	always #2 clk = ~clk;

	// 0 to 3 stall cycles, or none in zero-wait mode
	function automatic int draw_wait();
		if (!random_waits) begin
			return 0;
		end
		return int'($unsigned($random(seed)) % 4);
	endfunction

	// instruction memory, request accept then response
	always begin : inst_responder
		int          n;
		logic [31:0] fetch_pc;
		@(negedge clk);
		// the halt address is never answered so the core parks in IF
		if (!rst && inst_req_valid && pc != halt_pc) begin
			n = draw_wait();
			req_waits += n;
			repeat (n) @(negedge clk);
			fetch_pc = pc;
			fetch_q.push_back(fetch_pc);
			inst_req_ready = 1'b1;
			@(negedge clk);
			inst_req_ready = 1'b0;
			n = draw_wait();
			repeat (n) @(negedge clk);
			instruction = imem[fetch_pc[9:2]];
			inst_valid = 1'b1;
			@(negedge clk);
			inst_valid = 1'b0;
		end
	end

	// data memory, request accept then read data for loads
	always begin : data_responder
		int   n;
		logic is_read;
		@(negedge clk);
		if (!rst && (mem_read || mem_write)) begin
			n = draw_wait();
			mem_waits += n;
			repeat (n) @(negedge clk);
			is_read = mem_read;
			// request accepted on the next rising edge
			if (mem_write) begin
				store_addr_q.push_back(address);
				store_data_q.push_back(write_data);
				dmem[address[9:2]] = write_data;
			end
			read_data = dmem[address[9:2]];
			mem_req_ready = 1'b1;
			@(negedge clk);
			mem_req_ready = 1'b0;
			if (is_read) begin
				n = draw_wait();
				mem_waits += n;
				repeat (n) @(negedge clk);
				read_data_valid = 1'b1;
				@(negedge clk);
				read_data_valid = 1'b0;
			end
		end
	end

	task automatic finish_run();
		$display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	endtask

	`include "tb_tasks.svh"

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		inst_req_ready = 1'b0;
		instruction = '0;
		inst_valid = 1'b0;
		mem_req_ready = 1'b0;
		read_data = '0;
		read_data_valid = 1'b0;
		errors = 0;
		timeouts = 0;
		seed = 17641;
		random_waits = 1'b0;
		halt_pc = '0;
		prog_len = 0;
		req_waits = 0;
		mem_waits = 0;
		test_reset();
		test_alu();
		test_load_use();
		test_control_flow();
		test_backpressure();
		test_cycle_timing();
		finish_run();
	end

endmodule

// File: hdl/mips_multicycle_top.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module mips_multicycle_top (
	input  logic                 clk,
	input  logic                 rst,

	// instruction request
	output logic [`CPU_XLEN-1:0] pc,
	output logic                 inst_req_valid,
	input  logic                 inst_req_ready,

	// instruction response
	input  logic [`CPU_XLEN-1:0] instruction,
	input  logic                 inst_valid,
	output logic                 inst_ready,

	// memory request
	output logic [`CPU_XLEN-1:0] address,
	output logic                 mem_write,
	output logic [`CPU_XLEN-1:0] write_data,
	output logic                 mem_read,
	input  logic                 mem_req_ready,

	// read data response
	input  logic [`CPU_XLEN-1:0] read_data,
	input  logic                 read_data_valid,
	output logic                 read_data_ready,

	// status counters
	output logic [`CPU_XLEN-1:0] cycle_count,
	output logic [`CPU_XLEN-1:0] inst_count,
	output logic [`CPU_XLEN-1:0] mem_wait_count,
	output logic [`CPU_XLEN-1:0] branch_taken_count
);

	// state and decode shared by fsm, datapath and counters
	stage_if stage_bus ();

	control_fsm u_control_fsm (
		.clk(clk),
		.rst(rst),
		.ctrl(stage_bus),
		.inst_req_ready(inst_req_ready),
		.inst_valid(inst_valid),
		.mem_req_ready(mem_req_ready),
		.read_data_valid(read_data_valid),
		.inst_req_valid(inst_req_valid),
		.inst_ready(inst_ready),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.read_data_ready(read_data_ready)
	);

	datapath u_datapath (
		.clk(clk),
		.rst(rst),
		.ctrl(stage_bus),
		.instruction(instruction),
		.inst_valid(inst_valid),
		.read_data(read_data),
		.read_data_valid(read_data_valid),
		.pc(pc),
		.address(address),
		.write_data(write_data)
	);

	perf_counters u_perf_counters (
		.clk(clk),
		.rst(rst),
		.mon(stage_bus),
		.mem_req_ready(mem_req_ready),
		.read_data_valid(read_data_valid),
		.cycle_count(cycle_count),
		.inst_count(inst_count),
		.mem_wait_count(mem_wait_count),
		.branch_taken_count(branch_taken_count)
	);

endmodule

// File: hdl/perf_counters.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module perf_counters import core_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	stage_if.monitor             mon,
	input  logic                 mem_req_ready,
	input  logic                 read_data_valid,
	output logic [`CPU_XLEN-1:0] cycle_count,
	output logic [`CPU_XLEN-1:0] inst_count,
	output logic [`CPU_XLEN-1:0] mem_wait_count,
	output logic [`CPU_XLEN-1:0] branch_taken_count
);

	localparam int NUM_CNT = 4;

	logic [NUM_CNT-1:0]   evt;
	logic [`CPU_XLEN-1:0] cnt [NUM_CNT];

	// event per counter, sampled on the edge that ends the cycle
	assign evt[0] = 1'b1;
	assign evt[1] = (mon.state == st_if);
	// stalled memory request or read data not back yet
	assign evt[2] = (((mon.state == st_ld) || (mon.state == st_st)) && !mem_req_ready) ||
		((mon.state == st_rdw) && !read_data_valid);
	assign evt[3] = (mon.state == st_ex) && mon.branch_taken;

	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_CNT; i++) begin
			if (rst) begin
				cnt[i] <= '0;
			end else if (evt[i]) begin
				cnt[i] <= cnt[i] + 1'b1;
			end
		end
	end

	assign cycle_count = cnt[0];
	assign inst_count = cnt[1];
	assign mem_wait_count = cnt[2];
	assign branch_taken_count = cnt[3];

endmodule

// File: hdl/datapath.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module datapath import isa_pkg::*; import core_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	stage_if.dp                  ctrl,
	input  logic [`CPU_XLEN-1:0] instruction,
	input  logic                 inst_valid,
	input  logic [`CPU_XLEN-1:0] read_data,
	input  logic                 read_data_valid,
	output logic [`CPU_XLEN-1:0] pc,
	output logic [`CPU_XLEN-1:0] address,
	output logic [`CPU_XLEN-1:0] write_data
);

	logic [`CPU_XLEN-1:0] instr_q;
	logic [`CPU_XLEN-1:0] rdata_q;
	logic [`CPU_XLEN-1:0] op_a_q;
	logic [`CPU_XLEN-1:0] op_b_q;
	logic [`CPU_XLEN-1:0] alu_res_q;
	alu_op_e              alu_op_q;

	opcode_e                    opcode;
	funct_e                     funct;
	logic [`CPU_REG_ADDR_W-1:0] rs;
	logic [`CPU_REG_ADDR_W-1:0] rt;
	logic [`CPU_REG_ADDR_W-1:0] rd;
	logic [15:0]                imm;
	logic [25:0]                index;
	logic [`CPU_XLEN-1:0]       sign_ext;

	// decode results
	inst_class_e cls;
	alu_op_e     alu_op;
	logic        use_imm;
	logic        rd_dest;
	logic        is_lui;
	logic        is_jump;

	logic [`CPU_XLEN-1:0] alu_a;
	logic [`CPU_XLEN-1:0] alu_b;
	alu_op_e              alu_sel;
	logic [`CPU_XLEN-1:0] alu_y;
	logic                 alu_zero;

	logic [`CPU_XLEN-1:0] rdata1;
	logic [`CPU_XLEN-1:0] rdata2;
	logic                 rf_wen;
	logic [`CPU_REG_ADDR_W-1:0] rf_waddr;
	logic [`CPU_XLEN-1:0] rf_wdata;

	logic fetch_done;
	logic read_done;
	logic [`CPU_XLEN-1:0] br_target;
	logic [`CPU_XLEN-1:0] j_target;

	// transfers on the response channels
	assign fetch_done = (ctrl.state == st_iw) && inst_valid;
	assign read_done = (ctrl.state == st_rdw) && read_data_valid;

	always_ff @(posedge clk) begin
		if (fetch_done) begin
			instr_q <= instruction;
		end
		if (read_done) begin
			rdata_q <= read_data;
		end
	end

	// instruction fields
	assign opcode = opcode_e'(instr_q[31:26]);
	assign funct = funct_e'(instr_q[5:0]);
	assign rs = instr_q[25:21];
	assign rt = instr_q[20:16];
	assign rd = instr_q[15:11];
	assign imm = instr_q[15:0];
	assign index = instr_q[25:0];
	assign sign_ext = {{(`CPU_XLEN-16){imm[15]}}, imm};

	always_comb begin
		cls = cls_nop;
		alu_op = alu_add;
		use_imm = 1'b0;
		rd_dest = 1'b0;
		is_lui = 1'b0;
		case (opcode)
			op_special: begin
				rd_dest = 1'b1;
				cls = cls_writeback;
				case (funct)
					fn_addu: alu_op = alu_add;
					fn_subu: alu_op = alu_sub;
					fn_and:  alu_op = alu_and;
					fn_or:   alu_op = alu_or;
					fn_xor:  alu_op = alu_xor;
					fn_slt:  alu_op = alu_slt;
					// unknown funct falls through EX like a nop
					default: cls = cls_nop;
				endcase
			end
			op_addiu: begin
				cls = cls_writeback;
				use_imm = 1'b1;
			end
			op_lui: begin
				cls = cls_writeback;
				is_lui = 1'b1;
			end
			// base plus offset for both memory ops
			op_lw: begin
				cls = cls_load;
				use_imm = 1'b1;
			end
			op_sw: begin
				cls = cls_store;
				use_imm = 1'b1;
			end
			// compare rs against rt through the zero flag
			op_beq, op_bne: alu_op = alu_sub;
			default: ;
		endcase
	end

	assign is_jump = (opcode == op_j);
	assign ctrl.inst_class = cls;
	assign ctrl.inst_zero = ~|instr_q;

	// operands latched in ID so EX sees a stable alu input
	always_ff @(posedge clk) begin
		if (ctrl.state == st_id) begin
			alu_op_q <= alu_op;
			op_a_q <= rdata1;
			op_b_q <= use_imm ? sign_ext : rdata2;
		end
		if (ctrl.state == st_ex) begin
			alu_res_q <= alu_y;
		end
	end

	// shared alu works out pc+4 while waiting for the instruction
	assign alu_a = (ctrl.state == st_iw) ? pc : op_a_q;
	assign alu_b = (ctrl.state == st_iw) ? `CPU_XLEN'(4) : op_b_q;
	assign alu_sel = (ctrl.state == st_iw) ? alu_add : alu_op_q;

	alu u_alu (
		.a(alu_a),
		.b(alu_b),
		.op(alu_sel),
		.result(alu_y),
		.zero(alu_zero)
	);

	assign ctrl.branch_taken = ((opcode == op_beq) && alu_zero) ||
		((opcode == op_bne) && !alu_zero);

	// pc already holds pc+4 once EX is reached
	assign br_target = pc + {sign_ext[`CPU_XLEN-3:0], 2'b00};
	assign j_target = {pc[`CPU_XLEN-1:`CPU_XLEN-4], index, 2'b00};

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `CPU_RESET_PC;
		end else if (fetch_done) begin
			pc <= alu_y;
		end else if (ctrl.state == st_ex) begin
			if (ctrl.branch_taken) begin
				pc <= br_target;
			end else if (is_jump) begin
				pc <= j_target;
			end
		end
	end

	// word aligned memory request, full-word stores only
	assign address = {alu_res_q[`CPU_XLEN-1:2], 2'b00};
	assign write_data = rdata2;

	assign rf_wen = (ctrl.state == st_wb) && ((cls == cls_writeback) || (cls == cls_load));
	assign rf_waddr = rd_dest ? rd : rt;
	assign rf_wdata = (cls == cls_load) ? rdata_q :
		is_lui ? {imm, {(`CPU_XLEN-16){1'b0}}} : alu_res_q;

	reg_file u_reg_file (
		.clk(clk),
		.raddr1(rs),
		.raddr2(rt),
		.waddr(rf_waddr),
		.wdata(rf_wdata),
		.wen(rf_wen),
		.rdata1(rdata1),
		.rdata2(rdata2)
	);

endmodule

// File: hdl/control_fsm.sv
`timescale 1ns/1ps

module control_fsm import core_pkg::*; (
	input  logic clk,
	input  logic rst,
	stage_if.fsm ctrl,
	input  logic inst_req_ready,
	input  logic inst_valid,
	input  logic mem_req_ready,
	input  logic read_data_valid,
	output logic inst_req_valid,
	output logic inst_ready,
	output logic mem_read,
	output logic mem_write,
	output logic read_data_ready
);

	state_e state_q;
	state_e state_d;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= st_rst;
		end else begin
			state_q <= state_d;
		end
	end

	// next state, every wait state simply holds
	always_comb begin
		state_d = state_q;
		case (state_q)
			st_rst: state_d = st_if;
			st_if:  if (inst_req_ready) state_d = st_iw;
			st_iw:  if (inst_valid) state_d = st_id;
			// all-zero word is a nop and never reaches EX
			st_id:  state_d = ctrl.inst_zero ? st_if : st_ex;
			st_ex: begin
				case (ctrl.inst_class)
					cls_writeback: state_d = st_wb;
					cls_load:      state_d = st_ld;
					cls_store:     state_d = st_st;
					default:       state_d = st_if;
				endcase
			end
			st_ld:  if (mem_req_ready) state_d = st_rdw;
			st_st:  if (mem_req_ready) state_d = st_if;
			st_rdw: if (read_data_valid) state_d = st_wb;
			st_wb:  state_d = st_if;
			default: state_d = st_rst;
		endcase
	end

	assign ctrl.state = state_q;

	// handshake outputs come straight from the state
	assign inst_req_valid = (state_q == st_if);
	assign mem_read = (state_q == st_ld);
	assign mem_write = (state_q == st_st);
	// RST also accepts responses so stale ones get drained
	assign inst_ready = (state_q == st_rst) || (state_q == st_iw);
	assign read_data_ready = (state_q == st_rst) || (state_q == st_rdw);

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module reg_file (
	input  logic                       clk,
	input  logic [`CPU_REG_ADDR_W-1:0] raddr1,
	input  logic [`CPU_REG_ADDR_W-1:0] raddr2,
	input  logic [`CPU_REG_ADDR_W-1:0] waddr,
	input  logic [`CPU_XLEN-1:0]       wdata,
	input  logic                       wen,
	output logic [`CPU_XLEN-1:0]       rdata1,
	output logic [`CPU_XLEN-1:0]       rdata2
);

	logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

	always_ff @(posedge clk) begin
		if (wen) begin
			regs[waddr] <= wdata;
		end
	end

	// r0 is hardwired, whatever was written there
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module alu import isa_pkg::*; (
	input  logic [`CPU_XLEN-1:0] a,
	input  logic [`CPU_XLEN-1:0] b,
	input  alu_op_e              op,
	output logic [`CPU_XLEN-1:0] result,
	output logic                 zero
);

	logic [`CPU_XLEN-1:0] diff;
	logic                 less;

	assign diff = a - b;

	// signed compare
	// differing signs decide directly, else the difference sign cannot overflow
	assign less = (a[`CPU_XLEN-1] != b[`CPU_XLEN-1]) ? a[`CPU_XLEN-1] : diff[`CPU_XLEN-1];

	always_comb begin
		case (op)
			alu_add: result = a + b;
			alu_sub: result = diff;
			alu_and: result = a & b;
			alu_or:  result = a | b;
			alu_xor: result = a ^ b;
			alu_slt: result = {{(`CPU_XLEN-1){1'b0}}, less};
			default: result = '0;
		endcase
	end

	// used by beq and bne
	assign zero = ~|result;

endmodule

// File: hdl/stage_if.sv
`timescale 1ns/1ps

interface stage_if import core_pkg::*; ();

	// current core state, owned by the fsm
	state_e state;
	// decoded class of the held instruction, valid from ID on
	inst_class_e inst_class;
	// held instruction word is all zero, ID skips EX for it
	logic inst_zero;
	// branch condition met, only meaningful in EX
	logic branch_taken;

	modport fsm (output state, input inst_class, input inst_zero);

	modport dp (input state, output inst_class, output inst_zero, output branch_taken);

	// read-only view for status logic
	modport monitor (input state, input branch_taken);

endinterface

// File: hdl/core_pkg.sv
package core_pkg;

	// one-hot core states, one bit per state
	typedef enum logic [8:0] {
		st_rst = 9'b000000001,
		st_if  = 9'b000000010,
		st_iw  = 9'b000000100,
		st_id  = 9'b000001000,
		st_ex  = 9'b000010000,
		st_ld  = 9'b000100000,
		st_st  = 9'b001000000,
		st_rdw = 9'b010000000,
		st_wb  = 9'b100000000
	} state_e;

	// what follows EX for the held instruction
	// branches, jumps and unknown opcodes all return to IF
	typedef enum logic [1:0] {
		cls_nop       = 2'd0,
		cls_writeback = 2'd1,
		cls_load      = 2'd2,
		cls_store     = 2'd3
	} inst_class_e;

endpackage

// File: hdl/isa_pkg.sv
package isa_pkg;

	// primary opcode field, bits 31:26
	typedef enum logic [5:0] {
		op_special = 6'b000000,
		op_j       = 6'b000010,
		op_beq     = 6'b000100,
		op_bne     = 6'b000101,
		op_addiu   = 6'b001001,
		op_lui     = 6'b001111,
		op_lw      = 6'b100011,
		op_sw      = 6'b101011
	} opcode_e;

	// function field of SPECIAL, bits 5:0
	typedef enum logic [5:0] {
		fn_addu = 6'b100001,
		fn_subu = 6'b100011,
		fn_and  = 6'b100100,
		fn_or   = 6'b100101,
		fn_xor  = 6'b100110,
		fn_slt  = 6'b101010
	} funct_e;

	// alu operation select
	typedef enum logic [2:0] {
		alu_and = 3'b000,
		alu_or  = 3'b001,
		alu_add = 3'b010,
		alu_xor = 3'b100,
		alu_sub = 3'b110,
		alu_slt = 3'b111
	} alu_op_e;

endpackage

// File: hdl/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// data path and address width of the core
`define CPU_XLEN 32

// register specifier width in the instruction word
`define CPU_REG_ADDR_W 5

// address of the very first fetch out of reset
`define CPU_RESET_PC 32'h0000_0000

// architectural register count, r0 included
`define CPU_NREGS 32

`endif
